//--- list.f
hw/prog_flash_pkg.sv
hw/flash_ifs.sv
hw/flash_host_port.sv
hw/flash_addr_gen.sv
hw/flash_seq.sv
hw/flash_phy.sv
hw/prog_flash.sv
verif/flash_model.sv
verif/tb_prog_flash.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the prog_flash testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_prog_flash \
  -f list.f \
  --Mdir obj_dir -o sim_prog_flash

./obj_dir/sim_prog_flash | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- verif/tb_prog_flash.sv
`timescale 1ns/100ps
`default_nettype none

module tb_prog_flash;
  import prog_flash_pkg::*;

  localparam int     CLK_NS = 20;
  // buffer timeout test dominates, about 7 cycles per poll
  localparam longint WD_NS  = (longint'(BUF_POLL_MAX) + 1) * 8 * CLK_NS + 500_000;

  typedef enum {P_NONE, P_CLR, P_SETUP, P_ECONF, P_BUF, P_CNT, P_DAT, P_PCONF} phase_e;

  logic        p_in_clk = 1'b0;
  logic        p_in_rst = 1'b1;
  logic [31:0] usr_txd = '0;
  logic        usr_txrdy_n = 1'b1;
  wire         usr_rd;
  wire  [23:0] phy_adr;
  wire  [15:0] phy_d_in;
  wire  [15:0] phy_d_out;
  wire         dio_t;
  wire         oe_n;
  wire         we_n;
  wire         cs_n;
  wire         rdy;
  err_e        err;

  logic [7:0]  polls = 8'd1;
  logic        erase_fail = 1'b0;
  logic        buf_never = 1'b0;
  int          wr_cnt;
  int          econf_cnt;
  logic [23:0] wr_adr;
  logic [15:0] wr_d;

  logic [31:0] lfsr = 32'd72664;
  logic [31:0] fifo_q[$];
  logic [15:0] exp_q[$];
  int          errors = 0;
  int          seen_cnt = 0;
  int          pops = 0;
  int          exp_pops = 0;
  int          exp_econf = 0;
  int          exp_bufs = 0;
  int          buf_cnt = 0;
  int          widx = 0;
  logic        gaps = 1'b0;
  logic        rd_q = 1'b0;
  logic        ev = 1'b0;
  logic        rst_chk = 1'b0;
  logic        set_phase = 1'b0;
  logic        end_chk = 1'b0;
  phase_e      ph = P_NONE;
  logic [7:0]  blk = '0;
  logic [7:0]  end_blk = '0;
  logic [23:0] pbase = '0;
  logic [23:0] end_adr = '0;
  logic [15:0] exp_d = '0;
  logic [23:0] exp_a = '0;
  logic        exp_valid = 1'b0;
  err_e        exp_err = ERR_NONE;
  wire  [8:0]  rst_vec = {rdy, usr_rd, cs_n, we_n, oe_n, dio_t, err};

  prog_flash prog_flash_i (
    .i_usr_txd    (usr_txd),
    .i_usr_txrdy_n(usr_txrdy_n),
    .o_usr_rd     (usr_rd),
    .o_phy_adr    (phy_adr),
    .i_phy_d      (phy_d_in),
    .o_phy_d      (phy_d_out),
    .o_phy_dio_t  (dio_t),
    .o_phy_oe_n   (oe_n),
    .o_phy_we_n   (we_n),
    .o_phy_cs_n   (cs_n),
    .o_rdy        (rdy),
    .o_err        (err),
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst)
  );

  flash_model flash_i (
    .p_in_rst    (p_in_rst),
    .i_adr       (phy_adr),
    .i_d         (phy_d_out),
    .o_d         (phy_d_in),
    .i_cs_n      (cs_n),
    .i_we_n      (we_n),
    .i_oe_n      (oe_n),
    .i_polls     (polls),
    .i_erase_fail(erase_fail),
    .i_buf_never (buf_never),
    .o_wr_cnt    (wr_cnt),
    .o_wr_adr    (wr_adr),
    .o_wr_d      (wr_d),
    .o_econf_cnt (econf_cnt)
  );

  always #(CLK_NS / 2) p_in_clk = !p_in_clk;

  always @(posedge p_in_clk) rd_q <= usr_rd;  // pop seen by the DUT

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_reset_vals : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    rst_chk |-> rst_vec == 9'h170)
    else begin errors++; $display("CHECK FAILED rdy,rd,cs_n,we_n,oe_n,dio_t,err: got %h exp %h",
      rst_vec, 9'h170); end
  a_set_rdy : assert property (@(posedge p_in_clk) disable iff (p_in_rst) set_phase |-> rdy)
    else begin errors++; $display("CHECK FAILED o_rdy: got %h exp %h", rdy, 1'b1); end
  a_wr_legal : assert property (@(posedge p_in_clk) disable iff (p_in_rst) ev |-> exp_valid)
    else begin errors++; $display("flash write at %h with %h where none was due", wr_adr, wr_d); end
  a_wr_data : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    ev && exp_valid |-> wr_d == exp_d)
    else begin errors++; $display("CHECK FAILED o_phy_d: got %h exp %h", wr_d, exp_d); end
  a_wr_adr : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    ev && exp_valid |-> wr_adr == exp_a)
    else begin errors++; $display("CHECK FAILED o_phy_adr: got %h exp %h", wr_adr, exp_a); end
  a_end_err : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    end_chk |-> err == exp_err)
    else begin errors++; $display("CHECK FAILED o_err: got %h exp %h", err, exp_err); end
  a_end_rdy : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    end_chk |-> rdy == (exp_err == ERR_NONE))
    else begin errors++; $display("CHECK FAILED o_rdy: got %h exp %h", rdy, exp_err == ERR_NONE); end
  a_end_econf : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    end_chk |-> econf_cnt == exp_econf)
    else begin errors++; $display("CHECK FAILED erase confirms: got %h exp %h", econf_cnt,
      exp_econf); end
  a_end_bufs : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    end_chk |-> buf_cnt == exp_bufs)
    else begin errors++; $display("CHECK FAILED buffers: got %h exp %h", buf_cnt, exp_bufs); end
  a_end_pops : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    end_chk |-> pops == exp_pops)
    else begin errors++; $display("CHECK FAILED o_usr_rd pops: got %h exp %h", pops, exp_pops); end
  a_empty_pop : assert property (@(posedge p_in_clk) disable iff (p_in_rst) usr_rd |-> !usr_txrdy_n)
    else begin errors++; $display("o_usr_rd pulsed while the FIFO was empty"); end
  a_bus_fight : assert property (@(posedge p_in_clk) disable iff (p_in_rst) !(!we_n && !oe_n))
    else begin errors++; $display("o_phy_we_n and o_phy_oe_n both low"); end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // reference for the next flash write
  task automatic expect_write();
    exp_valid = 1'b1;
    case (ph)
      P_CLR   : begin exp_d = FL_CLR_SR; exp_a = {blk, 16'h0}; ph = P_SETUP; end
      P_SETUP : begin exp_d = FL_ERASE_SETUP; exp_a = {blk, 16'h0}; ph = P_ECONF; end
      P_ECONF :
      begin
        exp_d = FL_CONFIRM;
        exp_a = {blk, 16'h0};
        ph    = (erase_fail || blk == end_blk) ? P_NONE : P_CLR;
        blk++;
      end
      P_BUF :
      begin
        exp_d = FL_BUF_PROG;
        exp_a = pbase;
        if (!buf_never)
          ph = P_CNT;
      end
      P_CNT   : begin exp_d = 16'(BUF_WORDS - 1); exp_a = pbase; ph = P_DAT; widx = 0; end
      P_DAT :
      begin
        exp_d = (exp_q.size() > 0) ? exp_q.pop_front() : 16'h0000;
        exp_a = pbase + 24'(widx);
        widx++;
        if (widx == BUF_WORDS)
          ph = P_PCONF;
      end
      P_PCONF :
      begin
        exp_d = FL_CONFIRM;
        exp_a = pbase + 24'(BUF_WORDS);  // address already stepped past the buffer
        buf_cnt++;
        ph    = (end_adr < pbase + 24'(BUF_WORDS)) ? P_NONE : P_BUF;
        pbase = pbase + 24'(BUF_WORDS);
      end
      default : exp_valid = 1'b0;
    endcase
  endtask

  // one clock, inputs change on the falling edge
  task automatic cycle();
    logic [31:0] r;
    logic        gap;
    @(negedge p_in_clk);
    if (rd_q)
    begin
      if (fifo_q.size() > 0)
        void'(fifo_q.pop_front());
      pops++;
    end
    gap = 1'b0;
    if (gaps)
    begin
      take_bits(2, r);
      gap = (r[1:0] == 2'b11);
    end
    usr_txrdy_n = (fifo_q.size() == 0) || gap;
    usr_txd     = (fifo_q.size() > 0) ? fifo_q[0] : 32'h0;
    ev          = (wr_cnt != seen_cnt);
    if (ev)
    begin
      seen_cnt = wr_cnt;
      expect_write();
    end
  endtask

  task automatic apply_reset();
    p_in_rst = 1'b1;
    fifo_q.delete();
    exp_q.delete();
    ph = P_NONE;
    gaps = 1'b0;
    repeat (3) cycle();
    seen_cnt = 0;
    buf_cnt  = 0;
    p_in_rst = 1'b0;
    rst_chk  = 1'b1;
    cycle();
    rst_chk  = 1'b0;
  endtask

  task automatic set_range(input logic [7:0] sblk, input logic [23:0] eadr);
    set_phase = 1'b1;
    fifo_q.push_back({CMD_START_ADR, sblk, 8'h00});
    fifo_q.push_back({CMD_END_ADR, eadr});
    while (fifo_q.size() != 0)
      cycle();
    repeat (3) cycle();
    set_phase = 1'b0;
    pops      = 0;
  endtask

  task automatic wait_done();
    while (fifo_q.size() != 0 && err == ERR_NONE)
      cycle();
    cycle();
    while (!rdy && err == ERR_NONE)
      cycle();
  endtask

  task automatic check_end(input err_e e);
    exp_err = e;
    repeat (20) cycle();  // any late write shows up here
    end_chk = 1'b1;
    cycle();
    end_chk = 1'b0;
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic run_erase(input logic [7:0] sblk, input logic [23:0] eadr, input logic fail);
    logic [31:0] w;
    apply_reset();
    set_range(sblk, eadr);
    erase_fail = fail;
    buf_never  = 1'b0;
    blk        = sblk;
    end_blk    = eadr[23:16];
    ph         = P_CLR;
    take_bits(3, w);
    polls = {5'd0, w[2:0]} + 8'd1;
    fifo_q.push_back(CMD_ERASE);
    exp_econf = fail ? 1 : int'(end_blk) - int'(sblk) + 1;
    exp_bufs  = 0;
    exp_pops  = 1;
    wait_done();
    check_end(fail ? ERR_ERASE_STATUS : ERR_NONE);
  endtask

  task automatic run_program(input logic [7:0] sblk, input logic [23:0] eadr,
                             input logic with_gaps, input logic never);
    logic [31:0] w;
    int          nbuf;
    apply_reset();
    set_range(sblk, eadr);
    erase_fail = 1'b0;
    buf_never  = never;
    gaps       = with_gaps;
    pbase      = {sblk, 16'h0};
    end_adr    = eadr;
    nbuf       = int'(eadr - pbase) / BUF_WORDS + 1;
    ph         = P_BUF;
    take_bits(3, w);
    polls = {5'd0, w[2:0]} + 8'd1;
    fifo_q.push_back(CMD_PROGRAM);
    for (int i = 0; i < nbuf * BUF_WORDS / 2; i++)
    begin
      take_bits(32, w);
      fifo_q.push_back(w);
      exp_q.push_back({w[23:16], w[31:24]});
      exp_q.push_back({w[7:0], w[15:8]});
    end
    exp_econf = 0;
    exp_bufs  = never ? 0 : nbuf;
    exp_pops  = never ? 1 : 1 + nbuf * BUF_WORDS / 2;
    wait_done();
    check_end(never ? ERR_BUF_TIMEOUT : ERR_NONE);
  endtask

  initial
  begin
    run_erase(8'h03, 24'h05_1234, 1'b0);
    run_program(8'h07, 24'h07_0045, 1'b0, 1'b0);
    run_program(8'h07, 24'h07_0045, 1'b1, 1'b0);  // random FIFO gaps
    run_erase(8'h01, 24'h02_0000, 1'b1);
    run_program(8'h02, 24'h02_0010, 1'b0, 1'b1);
    $display("tests done, %0d errors", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    #(WD_NS);
    $display("watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/flash_model.sv
`timescale 1ns/100ps
`default_nettype none

module flash_model (
  input  wire        p_in_rst,
  input  wire [23:0] i_adr,
  input  wire [15:0] i_d,
  output logic [15:0] o_d,
  input  wire        i_cs_n,
  input  wire        i_we_n,
  input  wire        i_oe_n,
  input  wire [7:0]  i_polls,       // busy reads after a confirm
  input  wire        i_erase_fail,  // erase ends with 0xA0
  input  wire        i_buf_never,   // buffer never becomes ready
  output int         o_wr_cnt,
  output logic [23:0] o_wr_adr,
  output logic [15:0] o_wr_d,
  output int         o_econf_cnt
);
  import prog_flash_pkg::*;

  typedef enum {M_CMD, M_COUNT, M_DATA} mode_e;

  mode_e      mode = M_CMD;
  logic       erase_setup = 1'b0;
  int         data_left = 0;
  int         rd_cnt = 0;     // completed status reads
  int         ready_at = 0;   // read count where the result shows up
  logic [7:0] result = 8'h80;

  assign o_d = {8'h00, (rd_cnt >= ready_at) ? result : 8'h00};

  // status reads end on the rising edge of oe_n
  always @(posedge i_oe_n or posedge p_in_rst)
  begin
    if (p_in_rst)
      rd_cnt = 0;
    else if (i_cs_n === 1'b0)
      rd_cnt++;
  end

  // ------------------------------------------------------------
  // command decode, latched on the rising edge of we_n
  // ------------------------------------------------------------
  always @(posedge i_we_n or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      mode        = M_CMD;
      erase_setup = 1'b0;
      o_wr_cnt    = 0;
      o_econf_cnt = 0;
      ready_at    = 0;
      result      = 8'h80;
    end
    else if (i_cs_n === 1'b0)
    begin
      o_wr_cnt++;
      o_wr_adr = i_adr;
      o_wr_d   = i_d;
      case (mode)
        M_CMD :
          if (i_d == FL_ERASE_SETUP)
            erase_setup = 1'b1;
          else if (i_d == FL_CONFIRM)
          begin
            if (erase_setup)
              o_econf_cnt++;
            result      = (erase_setup && i_erase_fail) ? 8'hA0 : SR_READY;
            ready_at    = rd_cnt + int'(i_polls);
            erase_setup = 1'b0;
          end
          else if (i_d == FL_BUF_PROG)
          begin
            mode     = M_COUNT;
            result   = i_buf_never ? 8'h00 : SR_READY;
            ready_at = rd_cnt;
          end
        M_COUNT :
          if (i_d != FL_BUF_PROG)  // repeated setup while not ready
          begin
            data_left = int'(i_d) + 1;
            mode      = M_DATA;
          end
        default :
        begin
          data_left--;
          if (data_left == 0)
            mode = M_CMD;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/prog_flash.sv
`timescale 1ns/100ps
`default_nettype none

module prog_flash (
  input  wire [prog_flash_pkg::HOST_W-1:0] i_usr_txd,
  input  wire                              i_usr_txrdy_n,
  output logic                             o_usr_rd,
  output logic [prog_flash_pkg::ADR_W-1:0] o_phy_adr,
  input  wire  [prog_flash_pkg::DQ_W-1:0]  i_phy_d,
  output logic [prog_flash_pkg::DQ_W-1:0]  o_phy_d,
  output logic                             o_phy_dio_t,
  output logic                             o_phy_oe_n,
  output logic                             o_phy_we_n,  // flash latches on rising edge
  output logic                             o_phy_cs_n,
  output logic                             o_rdy,
  output prog_flash_pkg::err_e             o_err,
  input  wire                              p_in_clk,
  input  wire                              p_in_rst
);
  import prog_flash_pkg::*;

  logic             set_start;
  logic             set_end;
  logic [ADR_W-1:0] arg;
  logic             load_start;
  logic             next_blk;
  logic             next_word;
  logic             last_blk;
  logic             end_reached;
  logic [ADR_W-1:0] adr;

  host_word_if hw_if ();
  flash_bus_if bus_if ();

  flash_host_port host_port_i (
    .i_usr_txd    (i_usr_txd),
    .i_usr_txrdy_n(i_usr_txrdy_n),
    .o_usr_rd     (o_usr_rd),
    .o_set_start  (set_start),
    .o_set_end    (set_end),
    .o_arg        (arg),
    .hw           (hw_if.port),
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst)
  );

  flash_seq seq_i (
    .hw           (hw_if.seq),
    .bus          (bus_if.seq),
    .o_load_start (load_start),
    .o_next_blk   (next_blk),
    .o_next_word  (next_word),
    .i_last_blk   (last_blk),
    .i_end_reached(end_reached),
    .o_rdy        (o_rdy),
    .o_err        (o_err),
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst)
  );

  flash_addr_gen addr_gen_i (
    .i_set_start  (set_start),
    .i_set_end    (set_end),
    .i_arg        (arg),
    .i_load_start (load_start),
    .i_next_blk   (next_blk),
    .i_next_word  (next_word),
    .o_adr        (adr),
    .o_last_blk   (last_blk),
    .o_end_reached(end_reached),
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst)
  );

  flash_phy phy_i (
    .bus        (bus_if.phy),
    .i_adr      (adr),
    .o_phy_adr  (o_phy_adr),
    .i_phy_d    (i_phy_d),
    .o_phy_d    (o_phy_d),
    .o_phy_dio_t(o_phy_dio_t),
    .o_phy_oe_n (o_phy_oe_n),
    .o_phy_we_n (o_phy_we_n),
    .o_phy_cs_n (o_phy_cs_n),
    .p_in_clk   (p_in_clk),
    .p_in_rst   (p_in_rst)
  );

endmodule

`default_nettype wire

//--- hw/flash_phy.sv
`timescale 1ns/100ps
`default_nettype none

module flash_phy (
  flash_bus_if.phy                         bus,
  input  wire  [prog_flash_pkg::ADR_W-1:0] i_adr,
  output logic [prog_flash_pkg::ADR_W-1:0] o_phy_adr,
  input  wire  [prog_flash_pkg::DQ_W-1:0]  i_phy_d,
  output logic [prog_flash_pkg::DQ_W-1:0]  o_phy_d,
  output logic                             o_phy_dio_t,  // 1 = bus turned to input
  output logic                             o_phy_oe_n,
  output logic                             o_phy_we_n,
  output logic                             o_phy_cs_n,
  input  wire                              p_in_clk,
  input  wire                              p_in_rst
);
  import prog_flash_pkg::*;

  // ------------------------------------------------------------
  // control pins and status capture
  // ------------------------------------------------------------
  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      o_phy_cs_n  <= 1'b1;
      o_phy_we_n  <= 1'b1;
      o_phy_oe_n  <= 1'b1;
      o_phy_dio_t <= 1'b0;
      bus.status  <= '0;
    end
    else
    begin
      o_phy_cs_n  <= !bus.cs;
      o_phy_we_n  <= !bus.we;
      o_phy_oe_n  <= !bus.rd;
      o_phy_dio_t <= bus.rd;
      if (!o_phy_oe_n)  // end of the read cycle
        bus.status <= i_phy_d[SR_W-1:0];
    end
  end

  // address and write data
  always_ff @(posedge p_in_clk)
  begin
    o_phy_adr <= i_adr;
    o_phy_d   <= bus.dq;
  end

  a_no_bus_fight : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    !(!o_phy_we_n && !o_phy_oe_n));

endmodule

`default_nettype wire

//--- hw/flash_seq.sv
`timescale 1ns/100ps
`default_nettype none

module flash_seq (
  host_word_if.seq             hw,
  flash_bus_if.seq             bus,
  output logic                 o_load_start,
  output logic                 o_next_blk,
  output logic                 o_next_word,
  input  wire                  i_last_blk,
  input  wire                  i_end_reached,
  output logic                 o_rdy,
  output prog_flash_pkg::err_e o_err,
  input  wire                  p_in_clk,
  input  wire                  p_in_rst
);
  import prog_flash_pkg::*;

  seq_state_e        state;
  seq_state_e        ret;       // where a write or read pair returns
  host_op_e          op_q;
  logic [DQ_W-1:0]   dq_q;
  logic [POLL_W-1:0] poll_cnt;
  logic [WCNT_W-1:0] word_cnt;
  logic              end_seen;  // end address written in this buffer
  logic              sr_ok;

  assign sr_ok = (bus.status == SR_READY);

  // ------------------------------------------------------------
  // strobes to the host port, address generator and bus
  // ------------------------------------------------------------
  assign hw.cmd_take   = (state == S_IDLE);
  assign hw.hw_take    = (state == S_PG_DATA);
  assign o_load_start  = (state == S_CMD) && (op_q inside {OP_ERASE, OP_PROGRAM});
  assign o_next_blk    = (state == S_ER_CHK) && sr_ok && !i_last_blk;
  assign o_next_word   = (state == S_PG_NEXT);
  assign o_rdy         = (state == S_IDLE) || ((state == S_CMD) && !o_load_start);

  assign bus.cs = !(state inside {S_IDLE, S_CMD, S_ERR});
  assign bus.we = (state == S_WR);  // hold cycle follows with we low
  assign bus.rd = (state == S_RD);
  assign bus.dq = dq_q;

  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      state    <= S_IDLE;
      ret      <= S_IDLE;
      op_q     <= OP_NONE;
      dq_q     <= '0;
      poll_cnt <= '0;
      word_cnt <= '0;
      end_seen <= 1'b0;
      o_err    <= ERR_NONE;
    end
    else
    begin
      case (state)
        S_IDLE :
          if (hw.hw_valid)
          begin
            op_q  <= hw.cmd_op;
            state <= S_CMD;
          end
        S_CMD :
        begin
          poll_cnt <= '0;
          word_cnt <= '0;
          end_seen <= 1'b0;
          case (op_q)
            OP_ERASE   : state <= S_ER_BLK;
            OP_PROGRAM : state <= S_PG_BUF;
            default    : state <= S_IDLE;  // set commands finish here
          endcase
        end

        // shared write and read pairs
        S_WR   : state <= S_WR_H;
        S_WR_H : state <= ret;
        S_RD   : state <= S_RD_W;
        S_RD_W : state <= ret;  // status valid on return

        // ------------------------------------------------------------
        // block erase
        // ------------------------------------------------------------
        S_ER_BLK :
        begin
          dq_q  <= FL_CLR_SR;
          ret   <= S_ER_SETUP;
          state <= S_WR;
        end
        S_ER_SETUP :
        begin
          dq_q  <= FL_ERASE_SETUP;
          ret   <= S_ER_CONF;
          state <= S_WR;
        end
        S_ER_CONF :
        begin
          dq_q  <= FL_CONFIRM;
          ret   <= S_ER_POLL;
          state <= S_WR;
        end
        S_ER_POLL :
        begin
          ret   <= S_ER_CHK;
          state <= S_RD;
        end
        S_ER_CHK :
          if (sr_ok)
          begin
            poll_cnt <= '0;
            state    <= i_last_blk ? S_IDLE : S_ER_BLK;
          end
          else if (bus.status[7])  // ready with an error bit
          begin
            o_err <= ERR_ERASE_STATUS;
            state <= S_ERR;
          end
          else if (poll_cnt == ERASE_POLL_MAX)
          begin
            o_err <= ERR_ERASE_TIMEOUT;
            state <= S_ERR;
          end
          else
          begin
            poll_cnt <= poll_cnt + 1'b1;
            state    <= S_ER_POLL;
          end

        // ------------------------------------------------------------
        // buffer program
        // ------------------------------------------------------------
        S_PG_BUF :
        begin
          dq_q  <= FL_BUF_PROG;
          ret   <= S_PG_POLL;
          state <= S_WR;
        end
        S_PG_POLL :
        begin
          ret   <= S_PG_RDY;
          state <= S_RD;
        end
        S_PG_RDY :
          if (bus.status[7])
          begin
            poll_cnt <= '0;
            dq_q     <= DQ_W'(BUF_WORDS - 1);  // word count, n-1
            ret      <= S_PG_DATA;
            state    <= S_WR;
          end
          else if (poll_cnt == BUF_POLL_MAX)
          begin
            o_err <= ERR_BUF_TIMEOUT;
            state <= S_ERR;
          end
          else
          begin
            poll_cnt <= poll_cnt + 1'b1;
            state    <= S_PG_BUF;  // reissue the setup
          end
        S_PG_DATA :
          if (hw.hw_valid)  // otherwise wait for the FIFO
          begin
            dq_q  <= hw.hw_data;
            ret   <= S_PG_NEXT;
            state <= S_WR;
          end
        S_PG_NEXT :
        begin
          if (i_end_reached)
            end_seen <= 1'b1;
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == WCNT_W'(BUF_WORDS - 1))
          begin
            dq_q  <= FL_CONFIRM;
            ret   <= S_PG_FIN;
            state <= S_WR;
          end
          else
            state <= S_PG_DATA;
        end
        S_PG_FIN :
        begin
          ret   <= S_PG_DONE;
          state <= S_RD;
        end
        S_PG_DONE :
          if (sr_ok)
          begin
            poll_cnt <= '0;
            state    <= end_seen ? S_IDLE : S_PG_BUF;
          end
          else if (poll_cnt == BUF_POLL_MAX)
          begin
            o_err <= ERR_PROG_TIMEOUT;
            state <= S_ERR;
          end
          else
          begin
            poll_cnt <= poll_cnt + 1'b1;
            state    <= S_PG_FIN;
          end

        S_ERR   : state <= S_ERR;  // held until reset
        default : state <= S_IDLE;
      endcase
    end
  end

  a_idle_deselected : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    o_rdy |-> !bus.cs);

endmodule

`default_nettype wire

//--- hw/flash_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module flash_addr_gen (
  input  wire                              i_set_start,
  input  wire                              i_set_end,
  input  wire  [prog_flash_pkg::ADR_W-1:0] i_arg,
  input  wire                              i_load_start,
  input  wire                              i_next_blk,
  input  wire                              i_next_word,
  output logic [prog_flash_pkg::ADR_W-1:0] o_adr,
  output logic                             o_last_blk,
  output logic                             o_end_reached,
  input  wire                              p_in_clk,
  input  wire                              p_in_rst
);
  import prog_flash_pkg::*;

  logic [BLK_W-1:0] start_blk;
  logic [ADR_W-1:0] end_adr;

  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      start_blk <= '0;
      end_adr   <= '0;
      o_adr     <= '0;
    end
    else
    begin
      if (i_set_start)
        start_blk <= i_arg[15:8];
      if (i_set_end)
        end_adr <= i_arg;

      if (i_load_start)
        o_adr <= {start_blk, {(ADR_W - BLK_W){1'b0}}};
      else if (i_next_blk)  // all blocks 64K words
        o_adr <= {o_adr[ADR_W-1 -: BLK_W] + BLK_W'(1), {(ADR_W - BLK_W){1'b0}}};
      else if (i_next_word)
        o_adr <= o_adr + 1'b1;
    end
  end

  assign o_last_blk    = (o_adr[ADR_W-1 -: BLK_W] == end_adr[ADR_W-1 -: BLK_W]);
  assign o_end_reached = (o_adr == end_adr);

endmodule

`default_nettype wire

//--- hw/flash_host_port.sv
`timescale 1ns/100ps
`default_nettype none

module flash_host_port (
  input  wire [prog_flash_pkg::HOST_W-1:0] i_usr_txd,
  input  wire                              i_usr_txrdy_n,
  output logic                             o_usr_rd,
  output logic                             o_set_start,
  output logic                             o_set_end,
  output logic [prog_flash_pkg::ADR_W-1:0] o_arg,
  host_word_if.port                        hw,
  input  wire                              p_in_clk,
  input  wire                              p_in_rst
);
  import prog_flash_pkg::*;

  logic half_sel;  // 0 = bytes 23..16/31..24, 1 = bytes 7..0/15..8
  logic cmd_pop;
  logic hw_acc;

  assign hw.hw_valid = !i_usr_txrdy_n;

  // full-word codes first, the end code shares its top byte with erase
  always_comb
  begin
    if (i_usr_txd == CMD_ERASE)
      hw.cmd_op = OP_ERASE;
    else if (i_usr_txd == CMD_PROGRAM)
      hw.cmd_op = OP_PROGRAM;
    else if (i_usr_txd[31:16] == CMD_START_ADR)
      hw.cmd_op = OP_SET_START;
    else if (i_usr_txd[31:24] == CMD_END_ADR)
      hw.cmd_op = OP_SET_END;
    else
      hw.cmd_op = OP_NONE;  // dropped on pop
  end

  assign hw.hw_data = half_sel ? {i_usr_txd[7:0], i_usr_txd[15:8]}
                               : {i_usr_txd[23:16], i_usr_txd[31:24]};

  assign cmd_pop = hw.cmd_take && hw.hw_valid;
  assign hw_acc  = hw.hw_take && hw.hw_valid;

  assign o_usr_rd    = cmd_pop || (hw_acc && half_sel);  // second half frees the word
  assign o_set_start = cmd_pop && (hw.cmd_op == OP_SET_START);
  assign o_set_end   = cmd_pop && (hw.cmd_op == OP_SET_END);
  assign o_arg       = i_usr_txd[ADR_W-1:0];

  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
      half_sel <= 1'b0;
    else if (cmd_pop)
      half_sel <= 1'b0;
    else if (hw_acc)
      half_sel <= !half_sel;
  end

  a_no_pop_when_empty : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    o_usr_rd |-> !i_usr_txrdy_n);

endmodule

`default_nettype wire

//--- hw/flash_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// host word stream between the FIFO front end and the sequencer
interface host_word_if;
  import prog_flash_pkg::*;

  host_op_e        cmd_op;    // decode of the FIFO head
  logic            hw_valid;  // FIFO not empty
  logic [DQ_W-1:0] hw_data;   // swapped halfword
  logic            cmd_take;
  logic            hw_take;

  modport port (
    output cmd_op, hw_valid, hw_data,
    input  cmd_take, hw_take
  );

  modport seq (
    input  cmd_op, hw_valid, hw_data,
    output cmd_take, hw_take
  );
endinterface

// flash bus as seen one cycle before the pins
interface flash_bus_if;
  import prog_flash_pkg::*;

  logic            cs;      // active high here
  logic            we;
  logic            rd;
  logic [DQ_W-1:0] dq;
  logic [SR_W-1:0] status;  // last captured status byte

  modport seq (output cs, we, rd, dq, input status);
  modport phy (input cs, we, rd, dq, output status);
endinterface

`default_nettype wire

//--- hw/prog_flash_pkg.sv
`default_nettype none

package prog_flash_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int ADR_W  = 24;  // flash word address
  localparam int DQ_W   = 16;
  localparam int HOST_W = 32;
  localparam int BLK_W  = 8;   // address bits 23..16
  localparam int SR_W   = 8;   // status register byte
  localparam int POLL_W = 24;
  localparam int WCNT_W = 5;

  // host command words
  localparam logic [15:0] CMD_START_ADR = 16'h5341;        // top half only
  localparam logic [7:0]  CMD_END_ADR   = 8'h45;           // top byte only
  localparam logic [31:0] CMD_ERASE     = 32'h4572_6173;
  localparam logic [31:0] CMD_PROGRAM   = 32'h5072_6F67;

  // flash command set
  localparam logic [DQ_W-1:0] FL_CLR_SR      = 16'h0050;
  localparam logic [DQ_W-1:0] FL_ERASE_SETUP = 16'h0020;
  localparam logic [DQ_W-1:0] FL_CONFIRM     = 16'h00D0;
  localparam logic [DQ_W-1:0] FL_BUF_PROG    = 16'h00E8;

  localparam int BUF_WORDS = 32;  // halfwords per program buffer

  localparam logic [SR_W-1:0] SR_READY = 8'h80;

  // poll limits
  localparam logic [POLL_W-1:0] ERASE_POLL_MAX = 24'hF42400;
  localparam logic [POLL_W-1:0] BUF_POLL_MAX   = 24'h004650;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_SET_START,
    OP_SET_END,
    OP_ERASE,
    OP_PROGRAM
  } host_op_e;

  typedef enum logic [2:0] {
    ERR_NONE          = 3'd0,
    ERR_ERASE_STATUS  = 3'd2,
    ERR_ERASE_TIMEOUT = 3'd3,
    ERR_BUF_TIMEOUT   = 3'd4,
    ERR_PROG_TIMEOUT  = 3'd5
  } err_e;

  typedef enum logic [4:0] {
    S_IDLE, S_CMD,
    S_WR, S_WR_H, S_RD, S_RD_W,
    S_ER_BLK, S_ER_SETUP, S_ER_CONF, S_ER_POLL, S_ER_CHK,
    S_PG_BUF, S_PG_POLL, S_PG_RDY, S_PG_DATA, S_PG_NEXT, S_PG_FIN, S_PG_DONE,
    S_ERR
  } seq_state_e;

endpackage

`default_nettype wire
